/* earthrise.f */
+incdir+.
earthrise_pkg.sv
earthrise_regs.sv
earthrise_sequencer.sv
earthrise_raster.sv
earthrise_pixel_writer.sv
earthrise.sv
earthrise_checker.sv
tb_earthrise.sv

/* Bender.yml */
package:
  name: earthrise

export_include_dirs:
  - .

sources:
  - earthrise_pkg.sv
  - earthrise_regs.sv
  - earthrise_sequencer.sv
  - earthrise_raster.sv
  - earthrise_pixel_writer.sv
  - earthrise.sv
  - target: test
    files:
      - earthrise_checker.sv
      - tb_earthrise.sv

/* tb_earthrise.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the graphics engine. Runs a table of canvas setups
// and command lists against models of command and video memory, and
// compares every video memory write with the raster and packing rules.
//////////////////////////////////////////////////////////////////////

`include "earthrise_defines.svh"

`default_nettype none

module tb_earthrise;

    typedef struct packed {
        earthrise_pkg::canvas_t canvas;
        logic model;                  // 1: one rectangle, 0: no writes
        earthrise_pkg::job_t rect;    // corners as the program sets them
        logic inv;
        logic [0:11][15:0] prog;      // in execution order
    } case_t;

    logic clk = 1'b0;
    logic rst = 1'b1;
    earthrise_pkg::cfg_req_t cfg_req = '0;
    earthrise_pkg::cfg_rsp_t cfg_rsp;
    logic [`ER_CMD_ADDRW-1:0] cmd_addr;
    logic [`ER_WORD-1:0] cmd_data = '0;
    earthrise_pkg::vram_req_t vram_req;
    earthrise_pkg::vram_rsp_t vram_rsp = '0;
    logic done;

    logic [`ER_WORD-1:0] cmd_mem [2**`ER_CMD_ADDRW];
    earthrise_pkg::vram_req_t writes[$];    // acked writes in order
    earthrise_pkg::vram_req_t expected[$];
    case_t cases[$];
    int ack_wait = 0;

    earthrise dut (
        .clk, .rst, .cfg_req, .cfg_rsp, .cmd_addr, .cmd_data, .vram_req, .vram_rsp, .done
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cmd_data <= cmd_mem[cmd_addr];  // one clock read latency
    end

    // video memory slave, 0 to 3 wait cycles per write
    always @(posedge clk) begin
        if (rst || vram_rsp.ack) begin
            vram_rsp.ack <= 1'b0;
        end else if (vram_req.cyc && vram_req.stb) begin
            if (ack_wait == 0) begin
                vram_rsp.ack <= 1'b1;
                writes.push_back(vram_req);
                ack_wait <= $urandom % 4;
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_write(input int n, input earthrise_pkg::vram_req_t got,
                               input earthrise_pkg::vram_req_t exp);
        if (got !== exp) begin
            abort_run($sformatf(
                "CHECK FAILED vram_req[%0d] adr/dat/wmask got %h/%h/%h expected %h/%h/%h",
                n, got.adr, got.dat, got.wmask, exp.adr, exp.dat, exp.wmask));
        end
    endtask

    task automatic check_cfg(input string what, input earthrise_pkg::cfg_rsp_t got,
                             input earthrise_pkg::cfg_rsp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED cfg_rsp %s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_count(input int n, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("CHECK FAILED write count case %0d got %h expected %h",
                n, got, exp));
        end
    endtask

    task automatic cfg_access(input logic we, input logic [`ER_CFG_ADDRW-1:0] adr,
                              input logic [`ER_WORD-1:0] dat,
                              output earthrise_pkg::cfg_rsp_t rsp);
        int n;
        n = 0;
        @(posedge clk);
        cfg_req <= {1'b1, 1'b1, we, adr, dat};
        do begin
            @(negedge clk);
            n++;
        end while (!cfg_rsp.ack && n < 16);
        if (!cfg_rsp.ack) begin
            abort_run("configuration bus gave no ack");
        end
        rsp = cfg_rsp;
        @(posedge clk);
        cfg_req <= '0;
    endtask

    task automatic reg_write(input logic [`ER_CFG_ADDRW-1:0] adr, input logic [`ER_WORD-1:0] dat);
        earthrise_pkg::cfg_rsp_t rsp;
        cfg_access(1'b1, adr, dat, rsp);
    endtask

    task automatic reg_expect(input string what, input logic [`ER_CFG_ADDRW-1:0] adr,
                              input logic [`ER_WORD-1:0] exp);
        earthrise_pkg::cfg_rsp_t rsp;
        cfg_access(1'b0, adr, '0, rsp);
        check_cfg(what, rsp, {1'b1, exp});
    endtask

    // row-major over the sorted corners, clipped, packed by bpp
    task automatic expect_rect(input earthrise_pkg::canvas_t c, input earthrise_pkg::job_t r);
        int xa, xb, ya, yb, idx, ppw, sh;
        logic [`ER_WORD-1:0] ones;
        earthrise_pkg::vram_req_t e;
        xa = ($signed(r.x0) < $signed(r.x1)) ? $signed(r.x0) : $signed(r.x1);
        xb = ($signed(r.x0) < $signed(r.x1)) ? $signed(r.x1) : $signed(r.x0);
        ya = ($signed(r.y0) < $signed(r.y1)) ? $signed(r.y0) : $signed(r.y1);
        yb = ($signed(r.y0) < $signed(r.y1)) ? $signed(r.y1) : $signed(r.y0);
        ones = (32'd1 << c.bpp) - 1;
        ppw = 32 / c.bpp;           // pixels per word
        for (int y = ya; y <= yb; y++) begin
            for (int x = xa; x <= xb; x++) begin
                if (x >= 0 && y >= 0 && x < $signed(c.width) && y < $signed(c.height)) begin
                    idx = y * $signed(c.width) + x;
                    sh = (idx % ppw) * c.bpp;
                    e = '0;
                    e.cyc = 1'b1;
                    e.stb = 1'b1;
                    e.we = 1'b1;
                    e.adr = c.addr_base + idx / ppw;
                    e.dat = (r.colr & ones) << sh;
                    e.wmask = ones << sh;
                    expected.push_back(e);
                end
            end
        end
    endtask

    task automatic load_program(input logic [0:11][15:0] prog);
        for (int k = 0; k < 2**`ER_CMD_ADDRW; k++) begin
            if (k < 6) begin
                cmd_mem[k] = {prog[2*k+1], prog[2*k]};
            end else begin
                cmd_mem[k] = {8'hCC, 8'(k), 8'hCC, ~8'(k)};  // continue, tagged by address
            end
        end
    endtask

    task automatic add_case(input earthrise_pkg::canvas_t c, input logic m,
                            input earthrise_pkg::job_t r, input logic inv,
                            input logic [0:11][15:0] prog);
        cases.push_back({c, m, r, inv, prog});
    endtask

    task automatic run_case(input int i, input case_t tc);
        int n;
        load_program(tc.prog);
        reg_write(3'd1, `ER_WORD'(tc.canvas.width));
        reg_write(3'd2, `ER_WORD'(tc.canvas.height));
        reg_write(3'd3, `ER_WORD'(tc.canvas.bpp));
        reg_write(3'd4, `ER_WORD'(tc.canvas.addr_base));
        reg_expect("width", 3'd1, `ER_WORD'(tc.canvas.width));
        reg_expect("height", 3'd2, `ER_WORD'(tc.canvas.height));
        reg_expect("bpp", 3'd3, `ER_WORD'(tc.canvas.bpp));
        reg_expect("addr_base", 3'd4, `ER_WORD'(tc.canvas.addr_base));
        writes.delete();
        expected.delete();
        if (tc.model) begin
            expect_rect(tc.canvas, tc.rect);
        end
        reg_write(3'd0, 32'd1);     // start
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 5000) begin
                abort_run($sformatf("case %0d did not raise done in time", i));
            end
        end while (done !== 1'b1);
        check_count(i, writes.size(), expected.size());
        foreach (expected[k]) begin
            check_write(k, writes[k], expected[k]);
        end
        reg_expect("status", 3'd0, {30'd0, tc.inv, 1'b0});
    endtask

    initial begin
        void'($urandom(32'h91ce_5903));
        // canvas {w, h, bpp, base}, model, rect {x0, y0, x1, y1, colr}, invalid, program
        add_case({12'd16, 12'd8, 4'd1, 16'h100}, 1, {12'd5, 12'd3, 12'd5, 12'd3, 8'hA5}, 0,
                 192'h8002_9001_0003_1002_C0A5_D000_CE00_CE00_CE00_CE00_CE00_CE00);
        add_case({12'd16, 12'd8, 4'd2, 16'h200}, 1, {12'd7, 12'd3, 12'd7, 12'd3, 8'h3C}, 0,
                 192'h8001_9002_0006_1001_C13C_D002_CE00_CE00_CE00_CE00_CE00_CE00);
        add_case({12'd16, 12'd8, 4'd4, 16'h000}, 1, {12'd10, 12'd4, 12'd10, 12'd4, 8'h5E}, 0,
                 192'h8000_9000_000A_1004_C25E_D001_CE00_CE00_CE00_CE00_CE00_CE00);
        add_case({12'd16, 12'd8, 4'd8, 16'h010}, 1, {12'd5, 12'd1, 12'd5, 12'd1, 8'hC7}, 0,
                 192'h8003_9001_0002_1000_C3C7_D003_CE00_CE00_CE00_CE00_CE00_CE00);
        add_case({12'd16, 12'd8, 4'd8, 16'h000}, 1, {12'd3, 12'd3, 12'd3, 12'd3, 8'h44}, 1,
                 192'h8000_9000_C044_0003_1003_D000_4123_0005_D000_CE00_CE00_CE00);
        add_case({12'd16, 12'd8, 4'd8, 16'h040}, 1, {12'd6, 12'd4, 12'd4, 12'd2, 8'h77}, 0,
                 192'h8000_9000_C277_0006_1004_2004_3002_D401_CE00_CE00_CE00_CE00);
        add_case({12'd16, 12'd8, 4'd4, 16'h020}, 1, {12'd9, 12'd5, 12'd3, 12'd5, 8'hE1}, 0,
                 192'h8000_9000_C0E1_0009_1005_2003_3007_DF00_CE00_CE00_CE00_CE00);
        add_case({12'd16, 12'd8, 4'd8, 16'h000}, 0, {12'd0, 12'd0, 12'd0, 12'd0, 8'h00}, 1,
                 192'h8000_9000_C055_0004_1002_D100_D000_CE00_CE00_CE00_CE00_CE00);
        add_case({12'd8, 12'd6, 4'd2, 16'h080}, 1, {12'hFFE, 12'hFFF, 12'd9, 12'd5, 8'h9E}, 0,
                 192'h8FFE_9FFF_C39E_0000_1000_200B_3006_D403_CE00_CE00_CE00_CE00);
        add_case({12'd16, 12'd8, 4'd8, 16'h000}, 1, {12'd1, 12'd1, 12'd3, 12'd1, 8'h11}, 0,
                 192'h8000_9000_C011_0001_1001_2003_A012_CA00_D000_DF00_CE00_D400);
        add_case({12'd16, 12'd8, 4'd8, 16'h300}, 1, {12'd2, 12'd2, 12'd2, 12'd2, 8'h33}, 0,
                 192'h8000_9000_C033_0002_1002_D000_CC00_CC00_CC00_CC00_CC00_CC00);
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (vram_req.cyc !== 1'b0 || vram_req.stb !== 1'b0) begin
            abort_run("video memory cycle open after reset");
        end
        reg_expect("status after reset", 3'd0, 32'd0);
        reg_expect("bpp after reset", 3'd3, 32'd4);
        reg_write(3'd3, 32'd5);
        reg_expect("bpp fallback", 3'd3, 32'd4);   // unsupported depth reads as 4
        foreach (cases[i]) begin
            run_case(i, cases[i]);
        end
        repeat (4) @(posedge clk);
        if (dut.chk.fail_count != 0) begin
            abort_run($sformatf("%0d protocol assertion failures", dut.chk.fail_count));
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* earthrise_checker.sv */
//////////////////////////////////////////////////////////////////////
// Protocol checks for the graphics engine, bound into the top level.
// Covers the video memory write handshake, the configuration ack
// and the rule that done waits for open writes.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module earthrise_checker (
    input wire clk,
    input wire rst,
    input wire earthrise_pkg::cfg_rsp_t cfg_rsp,
    input wire earthrise_pkg::vram_req_t vram_req,
    input wire earthrise_pkg::vram_rsp_t vram_rsp,
    input wire done
);

    int fail_count = 0;

    // request held until the slave acks
    vram_hold: assert property (@(posedge clk) disable iff (rst)
        vram_req.cyc && !vram_rsp.ack |=> $stable(vram_req))
        else begin
            fail_count++;
            $error("video memory request changed before ack");
        end

    cfg_ack_once: assert property (@(posedge clk) disable iff (rst)
        cfg_rsp.ack |=> !cfg_rsp.ack)
        else begin
            fail_count++;
            $error("configuration ack longer than one cycle");
        end

    // all writes finish before done
    done_closed: assert property (@(posedge clk) disable iff (rst)
        done |-> !vram_req.cyc)
        else begin
            fail_count++;
            $error("done while a video memory cycle is open");
        end

endmodule

bind earthrise earthrise_checker chk (
    .clk, .rst, .cfg_rsp, .vram_req, .vram_rsp, .done
);

`default_nettype wire

/* earthrise.sv */
//////////////////////////////////////////////////////////////////////
// Graphics engine top level. Software sets up the canvas over the
// configuration port and starts a run; the engine reads commands
// and writes pixels to video memory until done pulses.
//////////////////////////////////////////////////////////////////////

`include "earthrise_defines.svh"

`default_nettype none

module earthrise (
    input  wire clk,
    input  wire rst,
    input  wire earthrise_pkg::cfg_req_t cfg_req,
    output wire earthrise_pkg::cfg_rsp_t cfg_rsp,
    output wire [`ER_CMD_ADDRW-1:0] cmd_addr,
    input  wire [`ER_WORD-1:0] cmd_data,
    output wire earthrise_pkg::vram_req_t vram_req,
    input  wire earthrise_pkg::vram_rsp_t vram_rsp,
    output wire done
);

    earthrise_pkg::canvas_t canvas;
    earthrise_pkg::job_t job;
    earthrise_pkg::pixel_t pix;
    logic start, busy, invalid;
    logic job_valid, job_ready;
    logic pix_valid, pix_ready;
    logic wr_idle;

    earthrise_regs regs_inst (
        .clk, .rst,
        .cfg_req, .cfg_rsp,
        .busy, .invalid,
        .canvas, .start
    );

    earthrise_sequencer seq_inst (
        .clk, .rst,
        .start,
        .cmd_addr, .cmd_data,
        .job, .job_valid, .job_ready,
        .wr_idle,
        .busy, .invalid, .done
    );

    earthrise_raster raster_inst (
        .clk, .rst,
        .job, .job_valid, .job_ready,
        .pix, .pix_valid, .pix_ready
    );

    earthrise_pixel_writer writer_inst (
        .clk, .rst,
        .canvas,
        .pix, .pix_valid, .pix_ready,
        .wr_idle,
        .vram_req, .vram_rsp
    );

endmodule

`default_nettype wire

/* earthrise_pixel_writer.sv */
//////////////////////////////////////////////////////////////////////
// Pixel writer: clips each pixel to the canvas, works out the video
// memory word, data lane and mask for the canvas depth, and runs one
// Wishbone classic write per visible pixel.
//////////////////////////////////////////////////////////////////////

`include "earthrise_defines.svh"

`default_nettype none

module earthrise_pixel_writer (
    input  wire clk,
    input  wire rst,
    input  wire earthrise_pkg::canvas_t canvas,
    input  wire earthrise_pkg::pixel_t pix,
    input  wire pix_valid,
    output logic pix_ready,
    output logic wr_idle,
    output earthrise_pkg::vram_req_t vram_req,
    input  wire earthrise_pkg::vram_rsp_t vram_rsp
);

    localparam int IDXW = 2 * `ER_CORDW;       // pixel index width
    localparam int OFFW = $clog2(`ER_WORD);    // bit offset in a word

    logic clip;
    logic [1:0] lg;                 // log2 of bpp
    logic [IDXW-1:0] index;
    logic [OFFW-1:0] offset;
    logic [`ER_WORD-1:0] lane;      // ones over one pixel at offset 0
    logic [`ER_VRAM_ADDRW-1:0] word_adr;

    always_comb begin
        case (canvas.bpp)
            4'd1:    lg = 2'd0;
            4'd2:    lg = 2'd1;
            4'd8:    lg = 2'd3;
            default: lg = 2'd2;
        endcase
    end

    assign clip = (pix.x < 0) || (pix.y < 0) ||
                  (pix.x >= canvas.width) || (pix.y >= canvas.height);

    // only meaningful when not clipped
    assign index = IDXW'($unsigned(pix.y)) * IDXW'($unsigned(canvas.width))
                 + IDXW'($unsigned(pix.x));
    assign word_adr = canvas.addr_base + `ER_VRAM_ADDRW'(index >> (OFFW - lg));
    assign offset = index[OFFW-1:0] << lg;  // slot times bpp
    assign lane = (`ER_WORD'(1) << (1 << lg)) - 1'b1;

    // no pixel held outside a bus cycle
    assign pix_ready = !vram_req.cyc;
    assign wr_idle   = !vram_req.cyc;

    always_ff @(posedge clk) begin
        if (rst) begin
            vram_req.cyc <= 1'b0;
            vram_req.stb <= 1'b0;
            vram_req.we  <= 1'b0;
        end else if (vram_req.cyc) begin
            if (vram_rsp.ack) begin
                vram_req.cyc <= 1'b0;
                vram_req.stb <= 1'b0;
                vram_req.we  <= 1'b0;
            end
        end else if (pix_valid && !clip) begin  // clipped pixels are dropped
            vram_req.cyc   <= 1'b1;
            vram_req.stb   <= 1'b1;
            vram_req.we    <= 1'b1;
            vram_req.adr   <= word_adr;
            vram_req.dat   <= (`ER_WORD'(pix.colr) & lane) << offset;
            vram_req.wmask <= lane << offset;
        end
    end

endmodule

`default_nettype wire

/* earthrise_raster.sv */
//////////////////////////////////////////////////////////////////////
// Rectangle rasterizer: sorts a job's corners and streams its pixels
// row by row, low y to high y and low x to high x, one per cycle.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module earthrise_raster (
    input  wire clk,
    input  wire rst,
    input  wire earthrise_pkg::job_t job,
    input  wire job_valid,
    output logic job_ready,
    output earthrise_pkg::pixel_t pix,
    output logic pix_valid,
    input  wire pix_ready
);

    logic running;
    earthrise_pkg::coord_t x, y;
    earthrise_pkg::coord_t x_lo, x_hi, y_hi;  // sorted bounds of current job
    earthrise_pkg::coord_t jx_min, jx_max, jy_min, jy_max;
    earthrise_pkg::colr_t colr;

    // corner sort on the incoming job
    assign jx_min = (job.x0 < job.x1) ? job.x0 : job.x1;
    assign jx_max = (job.x0 < job.x1) ? job.x1 : job.x0;
    assign jy_min = (job.y0 < job.y1) ? job.y0 : job.y1;
    assign jy_max = (job.y0 < job.y1) ? job.y1 : job.y0;

    assign job_ready = !running;
    assign pix_valid = running;
    assign pix = '{x: x, y: y, colr: colr};

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
        end else if (!running) begin
            if (job_valid) begin
                running <= 1'b1;
                x       <= jx_min;
                y       <= jy_min;
                x_lo    <= jx_min;
                x_hi    <= jx_max;
                y_hi    <= jy_max;
                colr    <= job.colr;
            end
        end else if (pix_ready) begin
            if (x != x_hi) begin
                x <= x + 1'b1;
            end else begin
                x <= x_lo;  // next row
                if (y == y_hi) running <= 1'b0;
                else y <= y + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* earthrise_sequencer.sv */
//////////////////////////////////////////////////////////////////////
// Command-list sequencer: fetches 16-bit instructions from command
// memory, keeps vertex, translation and colour registers, and hands
// drawing work to the raster as rectangle jobs.
//////////////////////////////////////////////////////////////////////

`include "earthrise_defines.svh"

`default_nettype none

module earthrise_sequencer (
    input  wire clk,
    input  wire rst,
    input  wire start,
    output logic [`ER_CMD_ADDRW-1:0] cmd_addr,
    input  wire [`ER_WORD-1:0] cmd_data,
    output earthrise_pkg::job_t job,
    output logic job_valid,
    input  wire job_ready,
    input  wire wr_idle,
    output logic busy,
    output logic invalid,
    output logic done
);

    localparam int PCW = `ER_CMD_ADDRW + 2;  // byte address
    localparam logic [PCW-1:0] PC_LAST = {{(PCW-1){1'b1}}, 1'b0};

    typedef enum logic [2:0] {
        S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_JUMP, S_DRAW, S_DRAIN, S_DONE
    } state_t;

    state_t state;
    logic [PCW-1:0] pc;
    logic [PCW-1:0] pc_start;      // jump target
    logic cmd_last;                // last command address decoded
    logic [`ER_WORD/2-1:0] instr_word;
    earthrise_pkg::instr_u ir;
    earthrise_pkg::coord_t tvx0, tvy0, tvx1, tvy1;
    earthrise_pkg::coord_t xt, yt;
    earthrise_pkg::coord_t imm_t;  // translated immediate
    earthrise_pkg::colr_t lca, lcb, fca, fcb;
    earthrise_pkg::colr_t colr_sel;

    assign cmd_addr = pc[PCW-1:2];
    assign instr_word = pc[1] ? cmd_data[`ER_WORD-1:`ER_WORD/2] : cmd_data[`ER_WORD/2-1:0];
    assign done = (state == S_DONE);

    // odd opcodes are y values
    assign imm_t = $signed(ir.imm_form.imm12) + (ir.imm_form.opcode[0] ? yt : xt);

    // option bit 0 picks fill, bit 1 picks colour B
    always_comb begin
        case (ir.fun_form.imm8[1:0])
            2'b00:   colr_sel = lca;
            2'b10:   colr_sel = lcb;
            2'b01:   colr_sel = fca;
            default: colr_sel = fcb;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            pc        <= '0;
            pc_start  <= '0;
            cmd_last  <= 1'b0;
            busy      <= 1'b0;
            invalid   <= 1'b0;
            job_valid <= 1'b0;
            xt        <= '0;
            yt        <= '0;
            lca       <= 'd1;
            lcb       <= 'd1;
            fca       <= 'd1;
            fcb       <= 'd1;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state   <= S_FETCH;
                        busy    <= 1'b1;
                        invalid <= 1'b0;
                    end
                end
                S_JUMP: state <= S_FETCH;  // let cmd_data follow the new pc
                S_FETCH: state <= cmd_last ? S_DRAIN : S_DECODE;
                S_DECODE: begin
                    ir    <= instr_word;
                    pc    <= pc + 2'd2;
                    state <= S_EXEC;
                    if (pc == PC_LAST) cmd_last <= 1'b1;
                end
                S_EXEC: begin
                    state <= S_FETCH;
                    case (ir.imm_form.opcode)
                        4'h0: tvx0 <= imm_t;
                        4'h1: tvy0 <= imm_t;
                        4'h2: tvx1 <= imm_t;
                        4'h3: tvy1 <= imm_t;
                        4'h8: xt <= ir.imm_form.imm12;
                        4'h9: yt <= ir.imm_form.imm12;
                        4'hA: pc_start <= ir.imm_form.imm12[PCW-1:0];
                        4'hC: begin
                            case (ir.fun_form.fun)
                                4'h0: lca <= ir.fun_form.imm8;
                                4'h1: lcb <= ir.fun_form.imm8;
                                4'h2: fca <= ir.fun_form.imm8;
                                4'h3: fcb <= ir.fun_form.imm8;
                                4'hA: begin  // jump
                                    pc       <= pc_start;
                                    cmd_last <= 1'b0;
                                    state    <= S_JUMP;
                                end
                                4'hC: ;  // continue
                                4'hE: state <= S_DRAIN;  // stop
                                default: begin
                                    invalid <= 1'b1;
                                    state   <= S_DRAIN;
                                end
                            endcase
                        end
                        4'hD: begin
                            job.x0   <= tvx0;
                            job.y0   <= tvy0;
                            job.colr <= colr_sel;
                            case (ir.fun_form.fun)
                                4'h0, 4'h4, 4'hF: begin
                                    job_valid <= 1'b1;
                                    state     <= S_DRAW;
                                end
                                default: begin
                                    invalid <= 1'b1;
                                    state   <= S_DRAIN;
                                end
                            endcase
                            job.x1 <= (ir.fun_form.fun == 4'h0) ? tvx0 : tvx1;  // pixel is 1x1
                            job.y1 <= (ir.fun_form.fun == 4'h4) ? tvy1 : tvy0;  // fast line is one row
                        end
                        default: begin
                            invalid <= 1'b1;
                            state   <= S_DRAIN;
                        end
                    endcase
                end
                S_DRAW: begin
                    if (job_ready) begin
                        job_valid <= 1'b0;
                        state     <= S_FETCH;
                    end
                end
                S_DRAIN: if (job_ready && wr_idle) state <= S_DONE;  // all writes finished
                default: begin  // S_DONE
                    busy     <= 1'b0;
                    pc       <= '0;
                    cmd_last <= 1'b0;
                    state    <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* earthrise_regs.sv */
//////////////////////////////////////////////////////////////////////
// Configuration and status registers on a Wishbone classic slave.
// Holds the canvas setup and issues the one-cycle engine start.
// Every request gets a single-cycle ack in the following cycle.
//////////////////////////////////////////////////////////////////////

`include "earthrise_defines.svh"

`default_nettype none

module earthrise_regs (
    input  wire clk,
    input  wire rst,
    input  wire earthrise_pkg::cfg_req_t cfg_req,
    output earthrise_pkg::cfg_rsp_t cfg_rsp,
    input  wire busy,
    input  wire invalid,
    output earthrise_pkg::canvas_t canvas,
    output logic start
);

    localparam logic [`ER_CFG_ADDRW-1:0] REG_CTRL   = 'd0;
    localparam logic [`ER_CFG_ADDRW-1:0] REG_WIDTH  = 'd1;
    localparam logic [`ER_CFG_ADDRW-1:0] REG_HEIGHT = 'd2;
    localparam logic [`ER_CFG_ADDRW-1:0] REG_BPP    = 'd3;
    localparam logic [`ER_CFG_ADDRW-1:0] REG_BASE   = 'd4;

    // unsupported depths fall back to 4 bpp
    function automatic logic [3:0] norm_bpp(input logic [3:0] v);
        case (v)
            4'd1, 4'd2, 4'd4, 4'd8: return v;
            default: return 4'd4;
        endcase
    endfunction

    logic req;                     // new request this cycle
    logic [`ER_WORD-1:0] rdata;

    assign req = cfg_req.cyc && cfg_req.stb && !cfg_rsp.ack;

    always_comb begin
        case (cfg_req.adr)
            REG_CTRL:   rdata = `ER_WORD'({invalid, busy});  // status
            REG_WIDTH:  rdata = `ER_WORD'(canvas.width);     // sign extended
            REG_HEIGHT: rdata = `ER_WORD'(canvas.height);
            REG_BPP:    rdata = `ER_WORD'(canvas.bpp);
            REG_BASE:   rdata = `ER_WORD'(canvas.addr_base);
            default:    rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_rsp.ack      <= 1'b0;
            start            <= 1'b0;
            canvas.width     <= '0;
            canvas.height    <= '0;
            canvas.bpp       <= 4'd4;
            canvas.addr_base <= '0;
        end else begin
            cfg_rsp.ack <= req;
            cfg_rsp.dat <= rdata;
            start <= req && cfg_req.we && (cfg_req.adr == REG_CTRL) && cfg_req.dat[0] && !busy;
            if (req && cfg_req.we) begin
                case (cfg_req.adr)
                    REG_WIDTH:  canvas.width     <= cfg_req.dat[`ER_CORDW-1:0];
                    REG_HEIGHT: canvas.height    <= cfg_req.dat[`ER_CORDW-1:0];
                    REG_BPP:    canvas.bpp       <= norm_bpp(cfg_req.dat[3:0]);
                    REG_BASE:   canvas.addr_base <= cfg_req.dat[`ER_VRAM_ADDRW-1:0];
                    default: ;  // CTRL handled by start
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* earthrise_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types of the graphics engine: instruction word, canvas,
// job and pixel records, and the two Wishbone bus bundles.
//////////////////////////////////////////////////////////////////////

`include "earthrise_defines.svh"

`default_nettype none

package earthrise_pkg;

    typedef logic signed [`ER_CORDW-1:0] coord_t;
    typedef logic [`ER_COLRW-1:0] colr_t;

    // one 16-bit instruction, read either way
    typedef struct packed {
        logic [3:0]  opcode;
        logic [11:0] imm12;  // vertex, translation or jump target
    } instr_imm_t;

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] fun;
        logic [7:0] imm8;  // colour value or draw options
    } instr_fun_t;

    typedef union packed {
        instr_imm_t imm_form;
        instr_fun_t fun_form;
    } instr_u;

    typedef struct packed {
        coord_t width;
        coord_t height;
        logic [3:0] bpp;                        // 1, 2, 4 or 8
        logic [`ER_VRAM_ADDRW-1:0] addr_base;   // word address of pixel (0,0)
    } canvas_t;

    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        colr_t  colr;
    } job_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        colr_t  colr;
    } pixel_t;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [`ER_CFG_ADDRW-1:0] adr;
        logic [`ER_WORD-1:0] dat;
    } cfg_req_t;

    typedef struct packed {
        logic ack;
        logic [`ER_WORD-1:0] dat;
    } cfg_rsp_t;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [`ER_VRAM_ADDRW-1:0] adr;
        logic [`ER_WORD-1:0] dat;
        logic [`ER_WORD-1:0] wmask;  // one bit per data bit
    } vram_req_t;

    typedef struct packed {
        logic ack;
    } vram_rsp_t;

endpackage

`default_nettype wire

/* earthrise_defines.svh */
//////////////////////////////////////////////////////////////////////
// Width and size macros for the command-list graphics engine.
// Included by the package and by any RTL file that sizes a port
// or a register directly from these values.
//////////////////////////////////////////////////////////////////////

`ifndef EARTHRISE_DEFINES_SVH
`define EARTHRISE_DEFINES_SVH

// integer coordinate width (signed)
`define ER_CORDW 12

// data word width on both buses
`define ER_WORD 32

`define ER_CMD_ADDRW 8    // command memory word address, pc is 2 bits wider
`define ER_VRAM_ADDRW 16  // video memory word address
`define ER_COLRW 8        // colour width

// configuration register index width
`define ER_CFG_ADDRW 3

`endif
